/* include/loader_macros.svh */
/*
 * Cartridge loader constants
 * Address width, header length, page sizes and memory bases
 */

`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// Cartridge memory address width
`define LOADER_ADDR_W 22

// iNES and FDS headers are both this long
`define LOADER_HDR_BYTES 16

// log2 of the page sizes
`define LOADER_PRG_SHIFT 14 // 16 KB PRG pages
`define LOADER_CHR_SHIFT 13 // 8 KB CHR pages

////////////////////////////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////////////////////////////

`define LOADER_CHR_BASE 'h200000 // CHR follows 2 MB of PRG space
`define LOADER_FDS_BASE 'h3C0010 // Disk data, past the skipped header

// Mapper reported for disk images
`define LOADER_FDS_MAPPER 8'd20

`endif

/* src/loader_pkg.sv */
/*
 * Loader types
 * Byte, address, mapper flag word and image kind shared by the loader
 */

`include "loader_macros.svh"

package loader_pkg;

	// One download or memory data byte
	typedef logic [7:0] byte_t;

	// Cartridge memory address
	typedef logic [`LOADER_ADDR_W-1:0] mem_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Mapper flags, listed from bit 31 down to bit 0
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic       spare;         // Always zero
		logic       piano;         // Miracle piano attached
		logic [3:0] prg_ram_shift; // NES 2.0 PRG-RAM size, 64 << n
		logic       saves;         // Battery backed RAM
		logic [7:0] submapper;     // NES 2.0 byte 8
		logic       four_screen;
		logic       chr_ram;       // No CHR ROM in the file
		logic       mirroring;
		logic [2:0] chr_size;      // Size class of CHR
		logic [2:0] prg_size;      // Size class of PRG
		logic [7:0] mapper;
	} mapper_flags_t;

	// What the header turned out to be
	typedef enum logic [1:0] {
		KIND_NONE, // Header not complete yet
		KIND_NES,
		KIND_FDS,
		KIND_BAD
	} image_kind_t;

endpackage

/* src/byte_receiver.sv */
/*
 * Download byte receiver
 * Four-phase req/ack slave, held off while the memory port is busy
 */

`timescale 1ns/100ps
`include "loader_macros.svh"

module byte_receiver (
	input  logic              clk,
	input  logic              reset_nes,
	input  logic              down_req,
	input  loader_pkg::byte_t down_data,
	input  logic              port_ready,
	output logic              down_ack,
	output logic              byte_strobe,
	output loader_pkg::byte_t byte_data
);
	import loader_pkg::*;

	logic accept;

	// New request, previous one fully closed, and room downstream
	assign accept = down_req && !down_ack && port_ready;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			down_ack    <= 1'b0;
			byte_strobe <= 1'b0;
		end else begin
			byte_strobe <= accept; // One cycle per byte
			if (accept)
				down_ack <= 1'b1;
			else if (down_ack && !down_req)
				down_ack <= 1'b0; // Close the handshake
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			byte_data <= down_data;
	end

	// Requester holds req until its ack shows up
	ack_needs_req: assert property (@(posedge clk) disable iff (reset_nes)
		$rose(down_ack) |-> down_req);

endmodule

/* src/ines_header_parser.sv */
/*
 * iNES / FDS header parser
 * Captures the first header bytes and decodes kind, page counts and flags
 */

`timescale 1ns/100ps
`include "loader_macros.svh"

module ines_header_parser (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      byte_strobe,
	input  loader_pkg::byte_t         byte_data,
	input  logic                      invert_mirroring,
	output loader_pkg::image_kind_t   hdr_kind,
	output loader_pkg::mapper_flags_t hdr_flags,
	output loader_pkg::byte_t         prg_pages,
	output loader_pkg::byte_t         chr_pages
);
	import loader_pkg::*;

	localparam int HDR_CNT_W = $clog2(`LOADER_HDR_BYTES);
	localparam logic [HDR_CNT_W-1:0] HDR_LAST = HDR_CNT_W'(`LOADER_HDR_BYTES - 1);

	byte_t                hdr_mem [`LOADER_HDR_BYTES];
	logic [HDR_CNT_W-1:0] hdr_cnt;
	logic                 hdr_full;
	logic                 is_nes_magic;
	logic                 is_fds_magic;
	logic                 is_nes20;
	logic                 is_dirty;
	mapper_flags_t        nes_flags;
	mapper_flags_t        fds_flags;

	// Page count to size class, 0..1 -> 0 up to >64 -> 7
	function automatic logic [2:0] size_class(input byte_t pages);
		logic [2:0] cls;
		if (pages <= 8'd1)       cls = 3'd0;
		else if (pages <= 8'd2)  cls = 3'd1;
		else if (pages <= 8'd4)  cls = 3'd2;
		else if (pages <= 8'd8)  cls = 3'd3;
		else if (pages <= 8'd16) cls = 3'd4;
		else if (pages <= 8'd32) cls = 3'd5;
		else if (pages <= 8'd64) cls = 3'd6;
		else                     cls = 3'd7;
		return cls;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Header capture
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			hdr_cnt  <= '0;
			hdr_full <= 1'b0;
		end else if (byte_strobe && !hdr_full) begin
			hdr_cnt <= hdr_cnt + 1'b1;
			if (hdr_cnt == HDR_LAST)
				hdr_full <= 1'b1; // Payload from here on
		end
	end

	always_ff @(posedge clk) begin
		if (byte_strobe && !hdr_full)
			hdr_mem[hdr_cnt] <= byte_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////
	assign is_nes_magic = hdr_mem[0] == 8'h4E && hdr_mem[1] == 8'h45 &&
		hdr_mem[2] == 8'h53 && hdr_mem[3] == 8'h1A; // "NES" EOF
	assign is_fds_magic = hdr_mem[0] == 8'h46 && hdr_mem[1] == 8'h44 &&
		hdr_mem[2] == 8'h53 && hdr_mem[3] == 8'h1A; // "FDS" EOF

	assign is_nes20 = hdr_mem[7][3:2] == 2'b10;

	// Old dumps with junk in the tail of the header
	assign is_dirty = !is_nes20 && (hdr_mem[9][7:1] != 7'd0 ||
		(hdr_mem[10] | hdr_mem[11] | hdr_mem[12] |
		 hdr_mem[13] | hdr_mem[14] | hdr_mem[15]) != 8'h00);

	always_comb begin
		nes_flags               = '0;
		nes_flags.mapper        = {is_dirty ? 4'h0 : hdr_mem[7][7:4], hdr_mem[6][7:4]};
		nes_flags.prg_size      = size_class(hdr_mem[4]);
		nes_flags.chr_size      = size_class(hdr_mem[5]);
		nes_flags.mirroring     = hdr_mem[6][0] ^ invert_mirroring;
		nes_flags.chr_ram       = hdr_mem[5] == 8'h00;
		nes_flags.four_screen   = hdr_mem[6][3];
		nes_flags.submapper     = is_nes20 ? hdr_mem[8] : 8'h00;
		nes_flags.saves         = hdr_mem[6][1];
		nes_flags.prg_ram_shift = is_nes20 ? hdr_mem[10][3:0] : 4'h0;
		nes_flags.piano         = is_nes20 && hdr_mem[15][5:0] == 6'h19;
	end

	// Fixed flags for disk images
	always_comb begin
		fds_flags           = '0;
		fds_flags.mapper    = `LOADER_FDS_MAPPER;
		fds_flags.prg_size  = 3'd7;
		fds_flags.chr_ram   = 1'b1;
		fds_flags.mirroring = invert_mirroring;
	end

	always_comb begin
		hdr_kind  = KIND_NONE;
		hdr_flags = '0;
		prg_pages = '0;
		chr_pages = '0;
		if (hdr_full) begin
			prg_pages = hdr_mem[4];
			chr_pages = hdr_mem[5];
			if (is_nes_magic && !hdr_mem[6][2]) begin // Trainers unsupported
				hdr_kind  = KIND_NES;
				hdr_flags = nes_flags;
			end else if (is_fds_magic) begin
				hdr_kind  = KIND_FDS;
				hdr_flags = fds_flags;
			end else begin
				hdr_kind = KIND_BAD;
			end
		end
	end

endmodule

/* src/load_sequencer.sv */
/*
 * Load sequencer
 * Walks header, PRG, CHR or FDS phases and generates write addresses
 */

`timescale 1ns/100ps
`include "loader_macros.svh"

module load_sequencer (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    byte_strobe,
	input  logic                    down_loading,
	input  loader_pkg::image_kind_t hdr_kind,
	input  loader_pkg::byte_t       prg_pages,
	input  loader_pkg::byte_t       chr_pages,
	output logic                    wr_strobe,
	output loader_pkg::mem_addr_t   wr_addr,
	output logic                    busy,
	output logic                    done,
	output logic                    error
);
	import loader_pkg::*;

	typedef enum logic [2:0] {
		PH_HEADER,
		PH_PRG,
		PH_CHR,
		PH_FDS,
		PH_DONE,
		PH_ERROR
	} phase_t;

	phase_t    phase;
	mem_addr_t bytes_left;
	mem_addr_t prg_bytes;
	mem_addr_t chr_bytes;

	assign prg_bytes = mem_addr_t'(prg_pages) << `LOADER_PRG_SHIFT;
	assign chr_bytes = mem_addr_t'(chr_pages) << `LOADER_CHR_SHIFT;

	// Which payload bytes become memory writes
	always_comb begin
		case (phase)
			PH_PRG, PH_CHR: wr_strobe = byte_strobe && bytes_left != '0;
			PH_FDS:         wr_strobe = byte_strobe && down_loading;
			default:        wr_strobe = 1'b0; // Trailing bytes are dropped
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Phase FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			phase      <= PH_HEADER;
			bytes_left <= '0;
			wr_addr    <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (phase)
				PH_HEADER: begin
					if (byte_strobe)
						busy <= 1'b1; // First header byte seen
					case (hdr_kind)
						KIND_NES: begin
							phase      <= PH_PRG;
							wr_addr    <= '0;
							bytes_left <= prg_bytes;
						end
						KIND_FDS: begin
							phase   <= PH_FDS;
							wr_addr <= mem_addr_t'(`LOADER_FDS_BASE);
						end
						KIND_BAD: begin
							phase <= PH_ERROR;
							busy  <= 1'b0;
							done  <= 1'b1;
							error <= 1'b1;
						end
						default: ;
					endcase
				end

				PH_PRG, PH_CHR: begin
					if (bytes_left == '0) begin
						if (phase == PH_PRG) begin
							phase      <= PH_CHR;
							wr_addr    <= mem_addr_t'(`LOADER_CHR_BASE);
							bytes_left <= chr_bytes; // Zero for CHR-RAM carts
						end else begin
							phase <= PH_DONE;
							busy  <= 1'b0;
							done  <= 1'b1;
						end
					end else if (wr_strobe) begin
						bytes_left <= bytes_left - 1'b1;
						wr_addr    <= wr_addr + 1'b1;
					end
				end

				// Disk image runs until the download ends
				PH_FDS: begin
					if (!down_loading) begin
						phase <= PH_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end else if (wr_strobe) begin
						wr_addr <= wr_addr + 1'b1;
					end
				end

				PH_DONE, PH_ERROR: ; // Hold until the next reset

				default: phase <= PH_HEADER;
			endcase
		end
	end

	// Decode result is taken before any payload byte can follow
	no_byte_at_decode: assert property (@(posedge clk) disable iff (reset_nes)
		phase == PH_HEADER && hdr_kind != KIND_NONE |-> !byte_strobe);

endmodule

/* src/mem_write_port.sv */
/*
 * Memory write port
 * One four-phase req/ack transaction per payload byte
 */

`timescale 1ns/100ps
`include "loader_macros.svh"

module mem_write_port (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  wr_strobe,
	input  loader_pkg::mem_addr_t wr_addr,
	input  loader_pkg::byte_t     byte_data,
	input  logic                  mem_ack,
	output logic                  port_ready,
	output logic                  mem_req,
	output loader_pkg::mem_addr_t mem_addr,
	output loader_pkg::byte_t     mem_data
);
	import loader_pkg::*;

	logic port_busy;

	// Busy from the strobe until ack has dropped again
	assign port_ready = !port_busy && !wr_strobe;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			port_busy <= 1'b0;
			mem_req   <= 1'b0;
		end else if (wr_strobe) begin
			port_busy <= 1'b1;
			mem_req   <= 1'b1;
		end else if (mem_req) begin
			if (mem_ack)
				mem_req <= 1'b0;
		end else if (port_busy && !mem_ack) begin
			port_busy <= 1'b0; // Return to zero complete
		end
	end

	// Address and data stay put for the whole transaction
	always_ff @(posedge clk) begin
		if (wr_strobe) begin
			mem_addr <= wr_addr;
			mem_data <= byte_data;
		end
	end

	// Request is still up when the memory answers
	req_holds: assert property (@(posedge clk) disable iff (reset_nes)
		$rose(mem_ack) |-> mem_req);

	// Back-pressure at the receiver keeps writes apart
	no_strobe_when_busy: assert property (@(posedge clk) disable iff (reset_nes)
		wr_strobe |-> !port_busy);

endmodule

/* src/nes_loader_top.sv */
/*
 * NES cartridge loader
 * Download bytes in, decoded mapper flags and cartridge memory writes out
 */

`timescale 1ns/100ps
`include "loader_macros.svh"

module nes_loader_top (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      down_req,
	input  loader_pkg::byte_t         down_data,
	input  logic                      down_loading,
	input  logic                      invert_mirroring,
	input  logic                      mem_ack,
	output logic                      down_ack,
	output logic                      mem_req,
	output loader_pkg::mem_addr_t     mem_addr,
	output loader_pkg::byte_t         mem_data,
	output loader_pkg::mapper_flags_t mapper_flags,
	output logic                      busy,
	output logic                      done,
	output logic                      error
);
	import loader_pkg::*;

	logic        byte_strobe;
	byte_t       byte_data;
	logic        port_ready;
	image_kind_t hdr_kind;
	byte_t       prg_pages;
	byte_t       chr_pages;
	logic        wr_strobe;
	mem_addr_t   wr_addr;

	////////////////////////////////////////////////////////////////////////////
	// Download side
	////////////////////////////////////////////////////////////////////////////
	byte_receiver u_receiver (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.down_req    (down_req),
		.down_data   (down_data),
		.port_ready  (port_ready),
		.down_ack    (down_ack),
		.byte_strobe (byte_strobe),
		.byte_data   (byte_data)
	);

	// Parser and sequencer both watch the byte strobe
	ines_header_parser u_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_strobe      (byte_strobe),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.hdr_kind         (hdr_kind),
		.hdr_flags        (mapper_flags),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages)
	);

	load_sequencer u_sequencer (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.byte_strobe  (byte_strobe),
		.down_loading (down_loading),
		.hdr_kind     (hdr_kind),
		.prg_pages    (prg_pages),
		.chr_pages    (chr_pages),
		.wr_strobe    (wr_strobe),
		.wr_addr      (wr_addr),
		.busy         (busy),
		.done         (done),
		.error        (error)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////////////////////
	mem_write_port u_mem_port (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.wr_strobe  (wr_strobe),
		.wr_addr    (wr_addr),
		.byte_data  (byte_data), // Straight from the receiver
		.mem_ack    (mem_ack),
		.port_ready (port_ready),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data)
	);

endmodule

/* sim/tb_mem_model.sv */
/*
 * Cartridge memory model
 * Acknowledges four-phase writes after a random delay and logs each one
 */

`timescale 1ns/100ps
`include "loader_macros.svh"

module tb_mem_model (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  mem_req,
	input  loader_pkg::mem_addr_t mem_addr,
	input  loader_pkg::byte_t     mem_data,
	output logic                  mem_ack
);
	import loader_pkg::*;

	localparam int LOG_DEPTH = 65536; // Largest test writes 40960 bytes

	mem_addr_t  addr_log [LOG_DEPTH];
	byte_t      data_log [LOG_DEPTH];
	int         wr_count = 0;
	int         seed     = 91271;
	logic       ack_r    = 1'b0;
	logic       pending  = 1'b0;
	logic [1:0] delay    = 2'd0;

	assign mem_ack = ack_r;

	////////////////////////////////////////////////////////////////////////////
	// Four-phase responder
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (reset_nes) begin
			ack_r    <= 1'b0;
			pending  <= 1'b0;
			wr_count <= 0;
		end else if (ack_r) begin
			if (!mem_req)
				ack_r <= 1'b0; // Return to zero
		end else if (mem_req) begin
			if (!pending) begin
				pending <= 1'b1;
				delay   <= 2'($random(seed)); // 0 to 3 wait cycles
			end else if (delay != 2'd0) begin
				delay <= delay - 2'd1;
			end else begin
				ack_r   <= 1'b1;
				pending <= 1'b0;
				// Keep the write for the checks
				if (wr_count < LOG_DEPTH) begin
					addr_log[wr_count] <= mem_addr;
					data_log[wr_count] <= mem_data;
				end
				wr_count <= wr_count + 1;
			end
		end
	end

endmodule

/* sim/tb_nes_loader.sv */
/*
 * NES loader testbench
 * Directed loads of iNES, FDS and bad images with header decode checks
 */

`timescale 1ns/100ps
`include "loader_macros.svh"

module tb_nes_loader;
	import loader_pkg::*;

	localparam int PRG_PAGE    = 1 << `LOADER_PRG_SHIFT;
	localparam int CHR_PAGE    = 1 << `LOADER_CHR_SHIFT;
	localparam int FDS_BYTES   = 64;
	localparam int TRAIL_BYTES = 4;
	localparam int NUM_TESTS   = 7;
	// Worst case is about 10 cycles per byte with the slowest memory
	localparam int BYTES_SENT  = NUM_TESTS * `LOADER_HDR_BYTES + PRG_PAGE +
		2 * PRG_PAGE + CHR_PAGE + 3 * TRAIL_BYTES + FDS_BYTES;
	localparam int CYCLE_LIMIT = 16 * BYTES_SENT + 100 * NUM_TESTS;

	logic          clk = 1'b0;
	logic          reset_nes;
	logic          down_req;
	byte_t         down_data;
	logic          down_loading;
	logic          invert_mirroring;
	logic          mem_ack;
	logic          down_ack;
	logic          mem_req;
	mem_addr_t     mem_addr;
	byte_t         mem_data;
	mapper_flags_t mapper_flags;
	logic          busy;
	logic          done;
	logic          error;

	byte_t hdr [`LOADER_HDR_BYTES]; // Header of the file being sent
	int    cycle_count = 0;

	always #10 clk = ~clk;

	nes_loader_top dut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.down_req         (down_req),
		.down_data        (down_data),
		.down_loading     (down_loading),
		.invert_mirroring (invert_mirroring),
		.mem_ack          (mem_ack),
		.down_ack         (down_ack),
		.mem_req          (mem_req),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	tb_mem_model mem (
		.clk       (clk),
		.reset_nes (reset_nes),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.mem_ack   (mem_ack)
	);

	////////////////////////////////////////////////////////////////////////////
	// Error handling and timeout
	////////////////////////////////////////////////////////////////////////////
	task stop_run();
		$display("sim failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task report_mismatch(input string msg);
		$display("MISMATCH at %0d ns: %s", $time, msg);
		stop_run();
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp,
		input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: flags %h, expected %h", what, got, exp));
	endtask

	task automatic check_write(input int idx, input mem_addr_t exp_addr, input byte_t exp_data);
		if (mem.addr_log[idx] !== exp_addr || mem.data_log[idx] !== exp_data)
			report_mismatch($sformatf("write %0d: %h <= %h, expected %h <= %h", idx,
				mem.addr_log[idx], mem.data_log[idx], exp_addr, exp_data));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			report_mismatch($sformatf("%s: %0d writes, expected %0d", what, got, exp));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Payload fill that depends on every bit of the index
	function automatic byte_t pattern(input int idx);
		return byte_t'(idx ^ (idx >> 8) ^ (idx >> 16) ^ 8'h5A);
	endfunction

	task automatic apply_reset(input logic inv);
		mapper_flags_t zero;
		zero = '0;
		@(posedge clk);
		reset_nes        <= 1'b1;
		down_req         <= 1'b0;
		down_data        <= 8'h00;
		down_loading     <= 1'b0;
		invert_mirroring <= inv;
		repeat (10) @(posedge clk);
		reset_nes <= 1'b0;
		@(posedge clk);
		check_bit(down_ack, 1'b0, "down_ack after reset");
		check_bit(mem_req, 1'b0, "mem_req after reset");
		check_bit(busy, 1'b0, "busy after reset");
		check_bit(done, 1'b0, "done after reset");
		check_bit(error, 1'b0, "error after reset");
		check_flags(mapper_flags, zero, "after reset");
	endtask

	task automatic make_ines(input byte_t prg, input byte_t chr, input byte_t b6,
		input byte_t b7);
		for (int i = 0; i < `LOADER_HDR_BYTES; i++)
			hdr[i] = 8'h00;
		hdr[0] = 8'h4E; // "NES" EOF
		hdr[1] = 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = b6;
		hdr[7] = b7;
	endtask

	// One full four-phase download handshake
	task automatic send_byte(input byte_t b);
		@(posedge clk);
		down_req  <= 1'b1;
		down_data <= b;
		@(posedge clk);
		while (!down_ack)
			@(posedge clk);
		down_req <= 1'b0;
		@(posedge clk);
		while (down_ack)
			@(posedge clk);
	endtask

	task automatic send_header();
		down_loading <= 1'b1; // High for the whole file
		for (int i = 0; i < `LOADER_HDR_BYTES; i++)
			send_byte(hdr[i]);
	endtask

	task automatic send_payload(input int count);
		for (int i = 0; i < count; i++)
			send_byte(pattern(i));
	endtask

	task automatic end_download();
		@(posedge clk);
		down_loading <= 1'b0;
	endtask

	task automatic wait_mem_idle();
		@(posedge clk);
		while (mem_req || mem_ack)
			@(posedge clk);
	endtask

	task automatic wait_done();
		@(posedge clk);
		while (!done)
			@(posedge clk);
		wait_mem_idle(); // Last write may still be in flight
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////
	task automatic one_prg_page_load();
		mapper_flags_t exp;
		exp = '0;
		apply_reset(1'b0);
		make_ines(8'd1, 8'd0, 8'h01, 8'h00);
		send_header();
		send_payload(PRG_PAGE);
		end_download();
		wait_done();
		exp.mirroring = 1'b1;
		exp.chr_ram   = 1'b1;
		check_flags(mapper_flags, exp, "one PRG page");
		check_bit(done, 1'b1, "done after PRG load");
		check_bit(error, 1'b0, "error after PRG load");
		check_bit(busy, 1'b0, "busy after PRG load");
		check_count(mem.wr_count, PRG_PAGE, "one PRG page");
		for (int i = 0; i < PRG_PAGE; i++)
			check_write(i, mem_addr_t'(i), pattern(i));
	endtask

	task automatic prg_chr_load();
		mapper_flags_t exp;
		int prg_len;
		exp = '0;
		prg_len = 2 * PRG_PAGE;
		apply_reset(1'b0);
		make_ines(8'd2, 8'd1, 8'h10, 8'h00); // Mapper 1
		send_header();
		send_payload(prg_len + CHR_PAGE + TRAIL_BYTES); // Trailing bytes dropped
		end_download();
		wait_done();
		exp.mapper   = 8'd1;
		exp.prg_size = 3'd1;
		check_flags(mapper_flags, exp, "PRG and CHR");
		check_bit(error, 1'b0, "error after PRG and CHR load");
		check_count(mem.wr_count, prg_len + CHR_PAGE, "PRG and CHR");
		for (int i = 0; i < prg_len; i++)
			check_write(i, mem_addr_t'(i), pattern(i));
		for (int i = 0; i < CHR_PAGE; i++)
			check_write(prg_len + i, mem_addr_t'(`LOADER_CHR_BASE + i), pattern(prg_len + i));
	endtask

	task automatic fds_load();
		mapper_flags_t exp;
		exp = '0;
		apply_reset(1'b1);
		make_ines(8'd1, 8'd0, 8'h00, 8'h00);
		hdr[0] = 8'h46; // "FDS" EOF
		hdr[1] = 8'h44;
		send_header();
		send_payload(FDS_BYTES);
		wait_mem_idle();
		repeat (4) @(posedge clk);
		check_bit(done, 1'b0, "done while disk still downloading");
		check_bit(busy, 1'b1, "busy while disk still downloading");
		end_download();
		wait_done();
		exp.mapper    = `LOADER_FDS_MAPPER;
		exp.prg_size  = 3'd7;
		exp.chr_ram   = 1'b1;
		exp.mirroring = 1'b1;
		check_flags(mapper_flags, exp, "FDS image");
		check_bit(error, 1'b0, "error after FDS load");
		check_count(mem.wr_count, FDS_BYTES, "FDS image");
		for (int i = 0; i < FDS_BYTES; i++)
			check_write(i, mem_addr_t'(`LOADER_FDS_BASE + i), pattern(i));
	endtask

	task automatic bad_header_load(input logic trainer, input string what);
		apply_reset(1'b0);
		make_ines(8'd1, 8'd0, trainer ? 8'h04 : 8'h00, 8'h00);
		if (!trainer)
			hdr[3] = 8'h1B; // Broken magic
		send_header();
		wait_done();
		check_bit(done, 1'b1, {what, " done"});
		check_bit(error, 1'b1, {what, " error"});
		check_bit(busy, 1'b0, {what, " busy"});
		send_payload(TRAIL_BYTES); // Acknowledged but never written
		end_download();
		wait_mem_idle();
		check_count(mem.wr_count, 0, what);
	endtask

	task automatic dirty_header_decode();
		mapper_flags_t exp;
		exp = '0;
		apply_reset(1'b0);
		make_ines(8'd0, 8'd0, 8'h31, 8'h40);
		hdr[12] = 8'h01; // Junk in the tail
		send_header();
		wait_done();
		end_download();
		exp.mapper    = 8'h03;
		exp.mirroring = 1'b1;
		exp.chr_ram   = 1'b1;
		check_flags(mapper_flags, exp, "dirty header");
		invert_mirroring <= 1'b1;
		repeat (2) @(posedge clk);
		exp.mirroring = 1'b0;
		check_flags(mapper_flags, exp, "dirty header, inverted mirroring");
		check_count(mem.wr_count, 0, "empty image");
	endtask

	task automatic ines2_header_decode();
		mapper_flags_t exp;
		exp = '0;
		apply_reset(1'b1);
		make_ines(8'd5, 8'd40, 8'h5A, 8'h18);
		hdr[8]  = 8'h37;
		hdr[10] = 8'hA6;
		hdr[12] = 8'hFF; // Not dirty in iNES 2.0
		hdr[15] = 8'hD9;
		send_header();
		@(posedge clk);
		exp.mapper        = 8'h15;
		exp.prg_size      = 3'd3;
		exp.chr_size      = 3'd6;
		exp.mirroring     = 1'b1;
		exp.four_screen   = 1'b1;
		exp.submapper     = 8'h37;
		exp.saves         = 1'b1;
		exp.prg_ram_shift = 4'h6;
		exp.piano         = 1'b1;
		check_flags(mapper_flags, exp, "iNES 2.0 header");
		check_bit(busy, 1'b1, "busy while waiting for PRG");
		check_bit(done, 1'b0, "done while waiting for PRG");
		end_download();
	endtask

	initial begin
		reset_nes        = 1'b1;
		down_req         = 1'b0;
		down_data        = 8'h00;
		down_loading     = 1'b0;
		invert_mirroring = 1'b0;

		one_prg_page_load();
		prg_chr_load();
		fds_load();
		bad_header_load(1'b0, "bad magic");
		bad_header_load(1'b1, "trainer");
		dirty_header_decode();
		ines2_header_decode();

		$display("sim passed");
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
src/loader_pkg.sv
src/byte_receiver.sv
src/ines_header_parser.sv
src/load_sequencer.sv
src/mem_write_port.sv
src/nes_loader_top.sv
sim/tb_mem_model.sv
sim/tb_nes_loader.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the NES loader testbench with Verilator
# The run counts as passed only if the pass line is in sim.log

rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_nes_loader -f sim.f -Mdir obj_dir > build.log 2>&1 &&
{ ./obj_dir/Vtb_nes_loader > sim.log 2>&1 || true; } &&
grep -qx "sim passed" sim.log &&
echo "PASS" ||
{ echo "FAIL, see build.log and sim.log"; exit 1; }
